/* hdl/pipeline_pkg.sv */
package pipeline_pkg;

    ////////////////////////////////////////
    // widths and basic types
    ////////////////////////////////////////

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // alu operations carried down the pipe
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    ////////////////////////////////////////
    // instruction fields
    ////////////////////////////////////////

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // wfi is the halt, funct12 = 0x105 on the system opcode
    localparam inst_t WFI_INST = {12'h105, 5'd0, 3'd0, 5'd0, OP_SYSTEM};

    // funct3 per operation
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, alt form selects sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

/* hdl/regfile.sv */
module regfile
    import pipeline_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rs1_val,
    output xlen_t    rs2_val,
    input  logic     wr_en,
    input  reg_idx_t wr_rd,
    input  xlen_t    wr_data
);

    xlen_t regs [NUM_REGS];

    // write port, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_rd != '0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // read ports
    // x0 first, then write-through, then array
    assign rs1_val = (rs1 == '0)                ? '0      :
                     (wr_en && wr_rd == rs1)    ? wr_data : regs[rs1];
    assign rs2_val = (rs2 == '0)                ? '0      :
                     (wr_en && wr_rd == rs2)    ? wr_data : regs[rs2];

endmodule

/* hdl/scoreboard.sv */
module scoreboard
    import pipeline_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     need_rs2,
    input  logic     issue,
    input  logic     writes,
    input  logic     clear_en,
    input  reg_idx_t clear_rd,
    output logic     stall
);

    // one busy bit per architectural register
    logic [NUM_REGS-1:0] busy;

    // busy and not retiring this cycle
    logic rs1_hit, rs2_hit, rd_hit;

    assign rs1_hit = busy[rs1] && !(clear_en && clear_rd == rs1);
    assign rs2_hit = need_rs2 && busy[rs2] && !(clear_en && clear_rd == rs2);
    assign rd_hit  = writes && busy[rd] && !(clear_en && clear_rd == rd);

    assign stall = rs1_hit || rs2_hit || rd_hit;

    ////////////////////////////////////////
    // busy bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            // clear first so a same-cycle reissue of rd wins
            if (clear_en) busy[clear_rd] <= 1'b0;
            if (issue && writes && rd != '0) busy[rd] <= 1'b1;
        end
    end

    // a retiring register was marked busy when it issued
    a_clear_was_busy: assert property (
        @(posedge clk) disable iff (reset)
        clear_en |-> busy[clear_rd]
    );

endmodule

/* hdl/fetch_stage.sv */
module fetch_stage
    import pipeline_pkg::*;
#(
    parameter xlen_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  halt_seen,
    output xlen_t icache_addr,
    input  inst_t icache_data,
    output inst_t if_id_inst,
    output logic  if_id_valid
);

    // program counter
    xlen_t pc;

    // instruction port always looks at the current pc
    assign icache_addr = pc;

    ////////////////////////////////////////
    // pc and if/id register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pc          <= RESET_PC;
            if_id_valid <= 1'b0;
        end else if (halt_seen) begin
            // fetch is done for good
            // drop whatever slipped in behind the halt
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            pc          <= pc + xlen_t'(4);
            if_id_valid <= 1'b1;
        end
        // pc and valid hold through a stall
    end

    // instruction word held beside the valid bit
    always_ff @(posedge clk) begin
        if (!stall && !halt_seen) begin
            if_id_inst <= icache_data;
        end
    end

    // word aligned fetch only
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        icache_addr[1:0] == 2'b00
    );

endmodule

/* hdl/decode_issue.sv */
module decode_issue
    import pipeline_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  inst_t    if_id_inst,
    input  logic     if_id_valid,
    input  logic     wb_en,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    output logic     stall,
    output logic     halt_seen,
    output logic     id_ex_valid,
    output reg_idx_t id_ex_rd,
    output logic     id_ex_writes,
    output alu_op_t  id_ex_op,
    output xlen_t    id_ex_a,
    output xlen_t    id_ex_b,
    output logic     id_ex_halt
);

    // instruction fields
    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    reg_idx_t   rs1, rs2, rd;
    xlen_t      imm, rs1_val, rs2_val;

    assign opcode = if_id_inst[6:0];
    assign rd     = if_id_inst[11:7];
    assign funct3 = if_id_inst[14:12];
    assign rs1    = if_id_inst[19:15];
    assign rs2    = if_id_inst[24:20];
    assign funct7 = if_id_inst[31:25];
    // i-type immediate, sign extended
    assign imm    = {{(XLEN-12){if_id_inst[31]}}, if_id_inst[31:20]};

    ////////////////////////////////////////
    // decoder
    ////////////////////////////////////////

    alu_op_t dec_op;
    logic    is_alu, is_reg, is_halt, dec_writes, sb_stall, issue, halt_q;

    always_comb begin
        dec_op = ALU_ADD;
        is_alu = 1'b0;
        if (opcode == OP_REG) begin
            is_alu = 1'b1;
            case ({funct7, funct3})
                {F7_BASE, F3_ADD_SUB}: dec_op = ALU_ADD;
                {F7_ALT,  F3_ADD_SUB}: dec_op = ALU_SUB;
                {F7_BASE, F3_AND}:     dec_op = ALU_AND;
                {F7_BASE, F3_OR}:      dec_op = ALU_OR;
                {F7_BASE, F3_XOR}:     dec_op = ALU_XOR;
                default:               is_alu = 1'b0;
            endcase
        end else if (opcode == OP_IMM && funct3 == F3_ADD_SUB) begin
            // addi only
            is_alu = 1'b1;
        end
    end

    assign is_reg     = is_alu && opcode == OP_REG;
    assign is_halt    = if_id_inst == WFI_INST;
    // unknown encodings fall through as a nop
    assign dec_writes = is_alu && rd != '0;

    // nothing issues once the halt has gone down
    assign issue     = if_id_valid && !halt_q && !sb_stall;
    assign stall     = if_id_valid && !halt_q && sb_stall;
    assign halt_seen = halt_q;

    regfile regfile_inst (
        .clk     (clk),
        .reset   (reset),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr_en   (wb_en),
        .wr_rd   (wb_rd),
        .wr_data (wb_data)
    );

    scoreboard scoreboard_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .need_rs2 (is_reg),
        .issue    (issue),
        .writes   (dec_writes),
        .clear_en (wb_en),
        .clear_rd (wb_rd),
        .stall    (sb_stall)
    );

    ////////////////////////////////////////
    // id/ex register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex_valid  <= 1'b0;
            id_ex_writes <= 1'b0;
            id_ex_halt   <= 1'b0;
            halt_q       <= 1'b0;
        end else begin
            // a stall leaves a bubble here
            id_ex_valid  <= issue;
            id_ex_writes <= issue && dec_writes;
            id_ex_halt   <= issue && is_halt;
            if (issue && is_halt) halt_q <= 1'b1;
        end
    end

    // operands and op, meaningful only with valid
    always_ff @(posedge clk) begin
        id_ex_rd <= rd;
        id_ex_op <= dec_op;
        id_ex_a  <= rs1_val;
        id_ex_b  <= is_reg ? rs2_val : imm;
    end

endmodule

/* hdl/execute_writeback.sv */
module execute_writeback
    import pipeline_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     id_ex_valid,
    input  reg_idx_t id_ex_rd,
    input  logic     id_ex_writes,
    input  alu_op_t  id_ex_op,
    input  xlen_t    id_ex_a,
    input  xlen_t    id_ex_b,
    input  logic     id_ex_halt,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output xlen_t    wb_data,
    output logic     halted
);

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////

    xlen_t alu_out;

    // add and sub wrap mod 2^32
    always_comb begin
        case (id_ex_op)
            ALU_ADD: alu_out = id_ex_a + id_ex_b;
            ALU_SUB: alu_out = id_ex_a - id_ex_b;
            ALU_AND: alu_out = id_ex_a & id_ex_b;
            ALU_OR:  alu_out = id_ex_a | id_ex_b;
            ALU_XOR: alu_out = id_ex_a ^ id_ex_b;
            default: alu_out = id_ex_a + id_ex_b;
        endcase
    end

    ////////////////////////////////////////
    // ex/wb register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en  <= 1'b0;
            halted <= 1'b0;
        end else begin
            wb_en <= id_ex_valid && id_ex_writes;
            // sticky until reset
            if (id_ex_valid && id_ex_halt) halted <= 1'b1;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        wb_rd   <= id_ex_rd;
        wb_data <= alu_out;
    end

    // x0 targets are filtered back in decode
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset)
        wb_en |-> wb_rd != '0
    );

    // nothing retires with a write after the halt
    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (reset)
        halted |=> !wb_en
    );

endmodule

/* hdl/pipeline.sv */
module pipeline
    import pipeline_pkg::*;
#(
    parameter xlen_t RESET_PC = '0
) (
    input  logic     clk,
    input  logic     reset,
    output xlen_t    icache_addr,
    input  inst_t    icache_data,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output xlen_t    commit_data,
    output logic     halted
);

    ////////////////////////////////////////
    // stage wires
    ////////////////////////////////////////

    // if/id
    inst_t    if_id_inst;
    logic     if_id_valid;

    // back to fetch
    logic     stall;
    logic     halt_seen;

    // id/ex
    logic     id_ex_valid;
    reg_idx_t id_ex_rd;
    logic     id_ex_writes;
    alu_op_t  id_ex_op;
    xlen_t    id_ex_a;
    xlen_t    id_ex_b;
    logic     id_ex_halt;

    // writeback loop into decode
    logic     wb_en;
    reg_idx_t wb_rd;
    xlen_t    wb_data;

    // commit port mirrors the writeback
    assign commit_valid = wb_en;
    assign commit_rd    = wb_rd;
    assign commit_data  = wb_data;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .halt_seen   (halt_seen),
        .icache_addr (icache_addr),
        .icache_data (icache_data),
        .if_id_inst  (if_id_inst),
        .if_id_valid (if_id_valid)
    );

    decode_issue decode_issue_inst (
        .clk          (clk),
        .reset        (reset),
        .if_id_inst   (if_id_inst),
        .if_id_valid  (if_id_valid),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .halt_seen    (halt_seen),
        .id_ex_valid  (id_ex_valid),
        .id_ex_rd     (id_ex_rd),
        .id_ex_writes (id_ex_writes),
        .id_ex_op     (id_ex_op),
        .id_ex_a      (id_ex_a),
        .id_ex_b      (id_ex_b),
        .id_ex_halt   (id_ex_halt)
    );

    execute_writeback execute_writeback_inst (
        .clk          (clk),
        .reset        (reset),
        .id_ex_valid  (id_ex_valid),
        .id_ex_rd     (id_ex_rd),
        .id_ex_writes (id_ex_writes),
        .id_ex_op     (id_ex_op),
        .id_ex_a      (id_ex_a),
        .id_ex_b      (id_ex_b),
        .id_ex_halt   (id_ex_halt),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .halted       (halted)
    );

endmodule

/* sim/pipeline_checks.svh */
`ifndef PIPELINE_CHECKS_SVH
`define PIPELINE_CHECKS_SVH

    ////////////////////////////////////////
    // typed compares
    ////////////////////////////////////////

    // register index of a commit
    task automatic check_reg(
        input string    name,
        input reg_idx_t expected,
        input reg_idx_t actual
    );
        if (actual !== expected) begin
            $display("[FAIL] %s expected x%0d actual x%0d", name, expected, actual);
            fail_run();
        end
    endtask

    // data or address word
    task automatic check_data(
        input string name,
        input xlen_t expected,
        input xlen_t actual
    );
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            fail_run();
        end
    endtask

    // single status level
    task automatic check_bit(
        input string name,
        input logic  expected,
        input logic  actual
    );
        if (actual !== expected) begin
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
            fail_run();
        end
    endtask

`endif

/* sim/pipeline_tb.sv */
module pipeline_tb
    import pipeline_pkg::*;
();

    ////////////////////////////////////////
    // sizes and stimulus
    ////////////////////////////////////////

    localparam string STIM_FILE    = "sim/program_input.txt";
    localparam int    IDX_BITS     = 6;
    localparam int    MAX_ENTRIES  = 2 ** IDX_BITS;
    localparam int    STIM_BITS    = 8;
    localparam int    STIM_DEPTH   = 2 ** STIM_BITS;
    localparam int    DRAIN_CYCLES = 4;
    // addi x0, x0, 0 past the end of the program
    localparam inst_t NOP_INST     = 32'h0000_0013;

    // dut side
    logic     clk = 1'b0;
    logic     reset;
    xlen_t    icache_addr;
    inst_t    icache_data = NOP_INST;
    logic     commit_valid;
    reg_idx_t commit_rd;
    xlen_t    commit_data;
    logic     halted;

    // raw file image split into program and expected commits
    logic [31:0] stim_words [STIM_DEPTH];
    inst_t       imem [MAX_ENTRIES];
    reg_idx_t    exp_rd [MAX_ENTRIES];
    xlen_t       exp_val [MAX_ENTRIES];

    int   prog_len;
    int   exp_count;
    int   commit_idx;
    int   cycle_count;
    int   cycle_limit;
    logic running;

    // first error ends the run
    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "pipeline_checks.svh"

    pipeline #(
        .RESET_PC ('0)
    ) pipeline_inst (
        .clk          (clk),
        .reset        (reset),
        .icache_addr  (icache_addr),
        .icache_data  (icache_data),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .halted       (halted)
    );

    // 40 unit period
    always #20 clk = ~clk;

    // header words, program words, then rd and value pairs
    task automatic load_stimulus();
        logic [STIM_BITS-1:0] pos;
        $readmemh(STIM_FILE, stim_words);
        prog_len  = int'(stim_words[0]);
        exp_count = int'(stim_words[1]);
        if (prog_len < 1 || prog_len > MAX_ENTRIES || exp_count > MAX_ENTRIES) begin
            $display("error: bad header in %s, %0d words and %0d commits",
                     STIM_FILE, prog_len, exp_count);
            fail_run();
        end
        pos = 8'd2;
        for (int i = 0; i < prog_len; i++) begin
            imem[i[IDX_BITS-1:0]] = stim_words[pos];
            pos = pos + 8'd1;
        end
        for (int i = 0; i < exp_count; i++) begin
            exp_rd[i[IDX_BITS-1:0]]  = reg_idx_t'(stim_words[pos]);
            exp_val[i[IDX_BITS-1:0]] = stim_words[pos + 8'd1];
            pos = pos + 8'd2;
        end
        // each word costs at most a few stall cycles
        cycle_limit = 8 * prog_len + 20;
    endtask

    ////////////////////////////////////////
    // instruction memory model
    ////////////////////////////////////////

    function automatic inst_t fetch_word(xlen_t addr);
        xlen_t word_idx;
        word_idx = addr >> 2;
        if (word_idx < xlen_t'(prog_len)) begin
            return imem[word_idx[IDX_BITS-1:0]];
        end
        return NOP_INST;
    endfunction

    // pc settles on the rising edge so data follows on the falling one
    always @(negedge clk) begin
        icache_data <= fetch_word(icache_addr);
    end

    ////////////////////////////////////////
    // commit monitor and timeout
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (running) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("error: timeout, halted did not rise within %0d cycles", cycle_limit);
                fail_run();
            end else if (commit_valid && commit_idx >= exp_count) begin
                $display("error: unexpected commit to x%0d after all %0d expected commits",
                         commit_rd, exp_count);
                fail_run();
            end else if (commit_valid) begin
                // one entry per commit in program order
                check_reg($sformatf("commit %0d rd", commit_idx),
                          exp_rd[commit_idx[IDX_BITS-1:0]], commit_rd);
                check_data($sformatf("commit %0d data", commit_idx),
                           exp_val[commit_idx[IDX_BITS-1:0]], commit_data);
                commit_idx = commit_idx + 1;
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        reset       = 1'b1;
        running     = 1'b0;
        commit_idx  = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_stimulus();

        // two cycles of reset released on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("reset commit_valid", 1'b0, commit_valid);
        check_bit("reset halted", 1'b0, halted);
        check_data("reset icache_addr", '0, icache_addr);
        reset   = 1'b0;
        running = 1'b1;

        // halt must come after the last expected commit
        while (!halted) @(negedge clk);
        if (commit_idx != exp_count) begin
            $display("error: halted rose after only %0d of %0d commits", commit_idx, exp_count);
            fail_run();
        end

        // the monitor catches stray commits behind the halt
        repeat (DRAIN_CYCLES) @(negedge clk);
        check_bit("halted held", 1'b1, halted);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* pipeline.f */
+incdir+sim
hdl/pipeline_pkg.sv
hdl/regfile.sv
hdl/scoreboard.sv
hdl/fetch_stage.sv
hdl/decode_issue.sv
hdl/execute_writeback.sv
hdl/pipeline.sv
sim/pipeline_tb.sv

/* Makefile */
# Verilator flow for the pipeline testbench, any variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILELIST  ?= pipeline.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/program_input.txt */
// header: program word count, expected commit count
// then one instruction word per line, then rd and value pairs in commit order
00000017 00000012
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
7FF00193 // addi x3, x0, 0x7ff
12300213 // addi x4, x0, 0x123
002082B3 // add  x5, x1, x2
40308333 // sub  x6, x1, x3
0041F3B3 // and  x7, x3, x4
00416433 // or   x8, x2, x4
0030C4B3 // xor  x9, x1, x3
00150513 // addi x10, x10, 1
00150513 // addi x10, x10, 1
00A505B3 // add  x11, x10, x10
40158633 // sub  x12, x11, x1
00B646B3 // xor  x13, x12, x11
00708013 // addi x0, x1, 7
00208033 // add  x0, x1, x2
00000733 // add  x14, x0, x0
05500793 // addi x15, x0, 0x55
00F06833 // or   x16, x0, x15
FFF08093 // addi x1, x1, -1
10500073 // wfi
00100893 // addi x17, x0, 1
00200913 // addi x18, x0, 2
// expected commits, rd then value
01 00000005  02 FFFFFFFD
03 000007FF  04 00000123
05 00000002  06 FFFFF806
07 00000123  08 FFFFFFFF
09 000007FA  0A 00000001
0A 00000002  0B 00000004
0C FFFFFFFF  0D FFFFFFFB
0E 00000000  0F 00000055
10 00000055  01 00000004
